// ==== logic/lane_consts.svh ====
`ifndef LANE_CONSTS_SVH
`define LANE_CONSTS_SVH

//////////////////////////////////////////////////
// Lane sizes
//////////////////////////////////////////////////
`define LANE_DATA_W			32
`define LANE_REG_COUNT		16

//////////////////////////////////////////////////
// Queue depths and latencies
//////////////////////////////////////////////////
`define LANE_CMD_DEPTH		4		// Also the sender's initial credits
`define LANE_ROB_DEPTH		8
`define LANE_MUL_LATENCY	3
`define LANE_COMMIT_DEPTH	4

`endif

// ==== logic/lane_pkg.sv ====
`include "lane_consts.svh"

package lane_pkg;

	typedef logic [`LANE_DATA_W-1:0]				data_t;
	typedef logic [$clog2(`LANE_REG_COUNT)-1:0]	reg_idx_t;
	typedef logic [7:0]							issue_no_t;		// Numbered by the scalar unit
	typedef logic [$clog2(`LANE_ROB_DEPTH)-1:0]	rob_tag_t;

	typedef enum logic [2:0] {
		OP_ADD	= 3'd0,
		OP_SUB	= 3'd1,
		OP_AND	= 3'd2,
		OP_XOR	= 3'd3,
		OP_MUL	= 3'd4,
		OP_MOVI	= 3'd5
	} opcode_t;

	// Command as held in the command queue
	typedef struct packed {
		opcode_t		opcode;
		reg_idx_t		dst;
		reg_idx_t		src1;
		reg_idx_t		src2;
		logic [15:0]	imm;
		issue_no_t		issue_no;
	} lane_cmd_t;

	// One retired instruction
	typedef struct packed {
		issue_no_t		issue_no;
		reg_idx_t		dst;
		data_t			data;
	} commit_t;

endpackage

// ==== logic/queue_fifo.sv ====
`timescale 1ns/10ps

module queue_fifo #(
	parameter type	payload_t	= logic,
	parameter int	depth		= 4
)(
	input	logic		clock,
	input	logic		reset,
	input	logic		push,
	input	payload_t	push_data,
	input	logic		pop,
	output	payload_t	pop_data,
	output	logic		empty,
	output	logic		full
);

	localparam int PTR_W = ( depth > 1 ) ? $clog2(depth) : 1;
	localparam int CNT_W = $clog2(depth + 1);

	payload_t			mem [depth];
	logic	[PTR_W-1:0]	rd_ptr;
	logic	[PTR_W-1:0]	wr_ptr;
	logic	[CNT_W-1:0]	count;
	logic				do_push;
	logic				do_pop;

	// Wrap for depths that are not a power of two
	function automatic logic [PTR_W-1:0] next_ptr( input logic [PTR_W-1:0] ptr );
		return ( ptr == PTR_W'(depth - 1) ) ? '0 : ptr + 1'b1;
	endfunction

	assign empty	= ( count == '0 );
	assign full		= ( count == CNT_W'(depth) );
	assign do_push	= push & ~full;
	assign do_pop	= pop & ~empty;
	assign pop_data	= mem[rd_ptr];		// Head visible without a pop

	always_ff @( posedge clock ) begin
		if ( reset ) begin
			rd_ptr	<= '0;
			wr_ptr	<= '0;
			count	<= '0;
		end
		else begin
			if ( do_push ) wr_ptr <= next_ptr(wr_ptr);
			if ( do_pop ) rd_ptr <= next_ptr(rd_ptr);
			case ( { do_push, do_pop } )
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;
			endcase
		end
	end

	always_ff @( posedge clock ) begin
		if ( do_push ) mem[wr_ptr] <= push_data;
	end

endmodule

// ==== logic/operand_fetch.sv ====
`timescale 1ns/10ps
`include "lane_consts.svh"

module operand_fetch (
	input	logic					clock,
	input	logic					reset,
	input	logic					cmd_empty,
	input	lane_pkg::lane_cmd_t	cmd_head,
	output	logic					cmd_pop,
	output	logic					rd_req,
	output	lane_pkg::reg_idx_t		rd_idx,
	input	logic					rd_gnt,
	input	lane_pkg::data_t		rd_data,
	output	logic					issue_valid,
	output	lane_pkg::opcode_t		issue_op,
	output	lane_pkg::data_t		issue_a,
	output	lane_pkg::data_t		issue_b,
	output	lane_pkg::rob_tag_t		issue_tag,
	input	logic					rob_full,
	output	logic					alloc_valid,
	output	lane_pkg::issue_no_t	alloc_issue_no,
	output	lane_pkg::reg_idx_t		alloc_dst,
	input	logic					retire_valid,
	input	lane_pkg::reg_idx_t		retire_dst
);
	import lane_pkg::*;

	typedef enum logic [1:0] { S_IDLE, S_RD_A, S_RD_B, S_LAST } state_t;

	state_t						state;
	logic [`LANE_REG_COUNT-1:0]	pending;	// Scoreboard, one bit per register
	rob_tag_t					next_tag;
	logic						rd_gnt_q;
	opcode_t					cur_op;
	reg_idx_t					cur_dst;
	reg_idx_t					cur_src1;
	reg_idx_t					cur_src2;
	rob_tag_t					cur_tag;
	data_t						op_a;
	logic						head_movi;
	logic						hazard;
	logic						issue_now;
	reg_idx_t					issue_dst;

	assign head_movi	= ( cmd_head.opcode == OP_MOVI );
	assign hazard		= pending[cmd_head.dst] |
							( ~head_movi & ( pending[cmd_head.src1] | pending[cmd_head.src2] ) );
	assign cmd_pop		= ~cmd_empty & ~hazard & ~rob_full & ( state == S_IDLE );

	// ROB slot is reserved at pop
	assign alloc_valid		= cmd_pop;
	assign alloc_issue_no	= cmd_head.issue_no;
	assign alloc_dst		= cmd_head.dst;

	assign rd_req		= ( state == S_RD_A ) | ( state == S_RD_B );
	assign rd_idx		= ( state == S_RD_A ) ? cur_src1 : cur_src2;

	assign issue_now	= ( cmd_pop & head_movi ) | ( state == S_LAST );
	assign issue_dst	= ( state == S_LAST ) ? cur_dst : cmd_head.dst;

	always_ff @( posedge clock ) begin
		if ( reset ) begin
			state		<= S_IDLE;
			pending		<= '0;
			next_tag	<= '0;
			rd_gnt_q	<= 1'b0;
			issue_valid	<= 1'b0;
		end
		else begin
			rd_gnt_q	<= rd_gnt;
			issue_valid	<= issue_now;
			if ( cmd_pop ) next_tag <= next_tag + 1'b1;
			if ( retire_valid ) pending[retire_dst] <= 1'b0;
			if ( issue_now ) pending[issue_dst] <= 1'b1;
			case ( state )
				S_IDLE:		if ( cmd_pop && !head_movi ) state <= S_RD_A;
				S_RD_A:		if ( rd_gnt ) state <= S_RD_B;
				S_RD_B:		if ( rd_gnt ) state <= S_LAST;
				default:	state <= S_IDLE;
			endcase
		end
	end

	always_ff @( posedge clock ) begin
		if ( cmd_pop ) begin
			cur_op		<= cmd_head.opcode;
			cur_dst		<= cmd_head.dst;
			cur_src1	<= cmd_head.src1;
			cur_src2	<= cmd_head.src2;
			cur_tag		<= next_tag;
		end
		if ( state == S_RD_B && rd_gnt_q ) op_a <= rd_data;		// src1 data lands here
		if ( cmd_pop && head_movi ) begin
			issue_op	<= OP_MOVI;
			issue_a		<= data_t'(cmd_head.imm);
			issue_b		<= '0;
			issue_tag	<= next_tag;
		end
		else if ( state == S_LAST ) begin
			issue_op	<= cur_op;
			issue_a		<= op_a;
			issue_b		<= rd_data;
			issue_tag	<= cur_tag;
		end
	end

endmodule

// ==== logic/rf_arbiter.sv ====
`timescale 1ns/10ps

module rf_arbiter (
	input	logic				clock,
	input	logic				reset,
	input	logic				rd_req,
	input	lane_pkg::reg_idx_t	rd_idx,
	output	logic				rd_gnt,
	input	logic				wb_req,
	input	lane_pkg::reg_idx_t	wb_idx,
	input	lane_pkg::data_t	wb_data,
	output	logic				wb_gnt,
	output	logic				port_we,
	output	lane_pkg::reg_idx_t	port_idx,
	output	lane_pkg::data_t	port_wdata
);

	logic	last_wb;		// Write-back won the last contest

	assign wb_gnt		= wb_req & ( ~rd_req | ~last_wb );
	assign rd_gnt		= rd_req & ~wb_gnt;

	assign port_we		= wb_gnt;
	assign port_idx		= wb_gnt ? wb_idx : rd_idx;
	assign port_wdata	= wb_data;

	always_ff @( posedge clock ) begin
		if ( reset ) begin
			last_wb <= 1'b0;
		end
		else if ( rd_gnt || wb_gnt ) begin
			last_wb <= wb_gnt;
		end
	end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/10ps
`include "lane_consts.svh"

module reg_file (
	input	logic				clock,
	input	logic				reset,
	input	logic				port_we,
	input	lane_pkg::reg_idx_t	port_idx,
	input	lane_pkg::data_t	port_wdata,
	output	lane_pkg::data_t	rd_data
);
	import lane_pkg::*;

	data_t	regs [`LANE_REG_COUNT];

	//////////////////////////////////////////////////
	// Register array
	//////////////////////////////////////////////////
	always_ff @( posedge clock ) begin
		if ( reset ) begin
			regs <= '{default: '0};
		end
		else if ( port_we ) begin
			regs[port_idx] <= port_wdata;
		end
	end

	// Registered read, one cycle after the grant
	always_ff @( posedge clock ) begin
		rd_data <= regs[port_idx];
	end

endmodule

// ==== logic/exec_unit.sv ====
`timescale 1ns/10ps
`include "lane_consts.svh"

module exec_unit (
	input	logic				clock,
	input	logic				reset,
	input	logic				issue_valid,
	input	lane_pkg::opcode_t	issue_op,
	input	lane_pkg::data_t	issue_a,
	input	lane_pkg::data_t	issue_b,
	input	lane_pkg::rob_tag_t	issue_tag,
	output	logic				alu_done,
	output	lane_pkg::rob_tag_t	alu_tag,
	output	lane_pkg::data_t	alu_data,
	output	logic				mul_done,
	output	lane_pkg::rob_tag_t	mul_tag,
	output	lane_pkg::data_t	mul_data
);
	import lane_pkg::*;

	localparam int LAT = `LANE_MUL_LATENCY;

	data_t				alu_result;
	logic				is_mul;
	logic [LAT-1:0]		mul_v;
	rob_tag_t			mul_t [LAT];
	data_t				mul_p [LAT];

	assign is_mul = ( issue_op == OP_MUL );

	always_comb begin
		case ( issue_op )
			OP_ADD:		alu_result = issue_a + issue_b;
			OP_SUB:		alu_result = issue_a - issue_b;
			OP_AND:		alu_result = issue_a & issue_b;
			OP_XOR:		alu_result = issue_a ^ issue_b;
			default:	alu_result = issue_a;		// MOVI immediate
		endcase
	end

	always_ff @( posedge clock ) begin
		if ( reset ) begin
			alu_done	<= 1'b0;
			mul_v		<= '0;
		end
		else begin
			alu_done	<= issue_valid & ~is_mul;
			mul_v		<= { mul_v[LAT-2:0], issue_valid & is_mul };
		end
	end

	always_ff @( posedge clock ) begin
		alu_tag		<= issue_tag;
		alu_data	<= alu_result;
		mul_t[0]	<= issue_tag;
		mul_p[0]	<= issue_a * issue_b;		// Low word kept
		for ( int i = 1; i < LAT; i++ ) begin
			mul_t[i]	<= mul_t[i-1];
			mul_p[i]	<= mul_p[i-1];
		end
	end

	assign mul_done	= mul_v[LAT-1];
	assign mul_tag	= mul_t[LAT-1];
	assign mul_data	= mul_p[LAT-1];

endmodule

// ==== logic/reorder_buffer.sv ====
`timescale 1ns/10ps
`include "lane_consts.svh"

module reorder_buffer (
	input	logic					clock,
	input	logic					reset,
	input	logic					alloc_valid,
	input	lane_pkg::issue_no_t	alloc_issue_no,
	input	lane_pkg::reg_idx_t		alloc_dst,
	output	logic					rob_full,
	input	logic					alu_done,
	input	lane_pkg::rob_tag_t		alu_tag,
	input	lane_pkg::data_t		alu_data,
	input	logic					mul_done,
	input	lane_pkg::rob_tag_t		mul_tag,
	input	lane_pkg::data_t		mul_data,
	output	logic					wb_req,
	output	lane_pkg::reg_idx_t		wb_idx,
	output	lane_pkg::data_t		wb_data,
	input	logic					wb_gnt,
	output	logic					retire_valid,
	output	lane_pkg::reg_idx_t		retire_dst,
	input	logic					commit_full,
	output	logic					commit_push,
	output	lane_pkg::commit_t		commit_rec
);
	import lane_pkg::*;

	localparam int DEPTH = `LANE_ROB_DEPTH;

	issue_no_t						ent_issue_no [DEPTH];
	reg_idx_t						ent_dst [DEPTH];
	data_t							ent_data [DEPTH];
	logic [DEPTH-1:0]				ent_done;
	rob_tag_t						head;
	rob_tag_t						tail;
	logic [$clog2(DEPTH+1)-1:0]		count;
	logic							head_ready;
	logic							retire;

	assign rob_full		= ( count == DEPTH );
	assign head_ready	= ( count != '0 ) & ent_done[head] & ~commit_full;
	assign retire		= head_ready & wb_gnt;

	//////////////////////////////////////////////////
	// Retire path, write-back and commit together
	//////////////////////////////////////////////////
	assign wb_req				= head_ready;
	assign wb_idx				= ent_dst[head];
	assign wb_data				= ent_data[head];
	assign retire_valid			= retire;
	assign retire_dst			= ent_dst[head];
	assign commit_push			= retire;
	assign commit_rec.issue_no	= ent_issue_no[head];
	assign commit_rec.dst		= ent_dst[head];
	assign commit_rec.data		= ent_data[head];

	always_ff @( posedge clock ) begin
		if ( reset ) begin
			head		<= '0;
			tail		<= '0;
			count		<= '0;
			ent_done	<= '0;
		end
		else begin
			if ( alloc_valid ) begin
				ent_done[tail]	<= 1'b0;
				tail			<= tail + 1'b1;
			end
			if ( alu_done ) ent_done[alu_tag] <= 1'b1;
			if ( mul_done ) ent_done[mul_tag] <= 1'b1;		// May share a cycle with ALU
			if ( retire ) head <= head + 1'b1;
			case ( { alloc_valid, retire } )
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;
			endcase
		end
	end

	always_ff @( posedge clock ) begin
		if ( alloc_valid ) begin
			ent_issue_no[tail]	<= alloc_issue_no;
			ent_dst[tail]		<= alloc_dst;
		end
		if ( alu_done ) ent_data[alu_tag] <= alu_data;
		if ( mul_done ) ent_data[mul_tag] <= mul_data;
	end

endmodule

// ==== logic/commit_port.sv ====
`timescale 1ns/10ps
`include "lane_consts.svh"

module commit_port (
	input	logic					clock,
	input	logic					reset,
	input	logic					commit_push,
	input	lane_pkg::commit_t		commit_rec,
	output	logic					commit_full,
	output	logic					commit_valid,
	output	lane_pkg::issue_no_t	commit_issue_no,
	output	lane_pkg::reg_idx_t		commit_dst,
	output	lane_pkg::data_t		commit_data,
	input	logic					commit_credit
);
	import lane_pkg::*;

	localparam int CREDIT_W = 8;

	commit_t				head_rec;
	logic					empty;
	logic					send;
	logic [CREDIT_W-1:0]	credits;

	queue_fifo #(
		.payload_t(	commit_t				),
		.depth(		`LANE_COMMIT_DEPTH		)
	) commit_queue (
		.clock(		clock					),
		.reset(		reset					),
		.push(		commit_push				),
		.push_data(	commit_rec				),
		.pop(		send					),
		.pop_data(	head_rec				),
		.empty(		empty					),
		.full(		commit_full				)
	);

	assign send				= ~empty & ( credits != '0 );
	assign commit_valid		= send;
	assign commit_issue_no	= head_rec.issue_no;
	assign commit_dst		= head_rec.dst;
	assign commit_data		= head_rec.data;

	// One credit per transfer
	always_ff @( posedge clock ) begin
		if ( reset ) begin
			credits <= '0;
		end
		else begin
			case ( { commit_credit, send } )
				2'b10:		credits <= credits + 1'b1;
				2'b01:		credits <= credits - 1'b1;
				default:	credits <= credits;
			endcase
		end
	end

endmodule

// ==== logic/simd_lane.sv ====
`timescale 1ns/10ps
`include "lane_consts.svh"

module simd_lane (
	input	logic					clock,
	input	logic					reset,
	input	logic					cmd_valid,
	input	lane_pkg::opcode_t		cmd_opcode,
	input	lane_pkg::reg_idx_t		cmd_dst,
	input	lane_pkg::reg_idx_t		cmd_src1,
	input	lane_pkg::reg_idx_t		cmd_src2,
	input	logic [15:0]			cmd_imm,
	input	lane_pkg::issue_no_t	cmd_issue_no,
	output	logic					cmd_credit,
	output	logic					commit_valid,
	output	lane_pkg::issue_no_t	commit_issue_no,
	output	lane_pkg::reg_idx_t		commit_dst,
	output	lane_pkg::data_t		commit_data,
	input	logic					commit_credit
);
	import lane_pkg::*;

	lane_cmd_t	cmd_in;
	lane_cmd_t	cmd_head;
	logic		cmd_empty;
	logic		cmd_pop;
	logic		rd_req;
	reg_idx_t	rd_idx;
	logic		rd_gnt;
	data_t		rd_data;
	logic		wb_req;
	reg_idx_t	wb_idx;
	data_t		wb_data;
	logic		wb_gnt;
	logic		port_we;
	reg_idx_t	port_idx;
	data_t		port_wdata;
	logic		issue_valid;
	opcode_t	issue_op;
	data_t		issue_a;
	data_t		issue_b;
	rob_tag_t	issue_tag;
	logic		alloc_valid;
	issue_no_t	alloc_issue_no;
	reg_idx_t	alloc_dst;
	logic		rob_full;
	logic		retire_valid;
	reg_idx_t	retire_dst;
	logic		alu_done;
	rob_tag_t	alu_tag;
	data_t		alu_data;
	logic		mul_done;
	rob_tag_t	mul_tag;
	data_t		mul_data;
	logic		commit_full;
	logic		commit_push;
	commit_t	commit_rec;

	assign cmd_in.opcode	= cmd_opcode;
	assign cmd_in.dst		= cmd_dst;
	assign cmd_in.src1		= cmd_src1;
	assign cmd_in.src2		= cmd_src2;
	assign cmd_in.imm		= cmd_imm;
	assign cmd_in.issue_no	= cmd_issue_no;
	assign cmd_credit		= cmd_pop;		// Slot freed, credit back to sender

	//////////////////////////////////////////////////
	// Intake and issue
	//////////////////////////////////////////////////
	queue_fifo #(
		.payload_t(	lane_cmd_t			),
		.depth(		`LANE_CMD_DEPTH		)
	) cmd_queue (
		.clock(		clock				),
		.reset(		reset				),
		.push(		cmd_valid			),
		.push_data(	cmd_in				),
		.pop(		cmd_pop				),
		.pop_data(	cmd_head			),
		.empty(		cmd_empty			),
		.full(							)
	);

	operand_fetch operand_fetch (
		.clock(				clock			),
		.reset(				reset			),
		.cmd_empty(			cmd_empty		),
		.cmd_head(			cmd_head		),
		.cmd_pop(			cmd_pop			),
		.rd_req(			rd_req			),
		.rd_idx(			rd_idx			),
		.rd_gnt(			rd_gnt			),
		.rd_data(			rd_data			),
		.issue_valid(		issue_valid		),
		.issue_op(			issue_op		),
		.issue_a(			issue_a			),
		.issue_b(			issue_b			),
		.issue_tag(			issue_tag		),
		.rob_full(			rob_full		),
		.alloc_valid(		alloc_valid		),
		.alloc_issue_no(	alloc_issue_no	),
		.alloc_dst(			alloc_dst		),
		.retire_valid(		retire_valid	),
		.retire_dst(		retire_dst		)
	);

	//////////////////////////////////////////////////
	// Register file port
	//////////////////////////////////////////////////
	rf_arbiter rf_arbiter (
		.clock(			clock			),
		.reset(			reset			),
		.rd_req(		rd_req			),
		.rd_idx(		rd_idx			),
		.rd_gnt(		rd_gnt			),
		.wb_req(		wb_req			),
		.wb_idx(		wb_idx			),
		.wb_data(		wb_data			),
		.wb_gnt(		wb_gnt			),
		.port_we(		port_we			),
		.port_idx(		port_idx		),
		.port_wdata(	port_wdata		)
	);

	reg_file reg_file (
		.clock(			clock			),
		.reset(			reset			),
		.port_we(		port_we			),
		.port_idx(		port_idx		),
		.port_wdata(	port_wdata		),
		.rd_data(		rd_data			)
	);

	//////////////////////////////////////////////////
	// Execute and retire
	//////////////////////////////////////////////////
	exec_unit exec_unit (
		.clock(			clock			),
		.reset(			reset			),
		.issue_valid(	issue_valid		),
		.issue_op(		issue_op		),
		.issue_a(		issue_a			),
		.issue_b(		issue_b			),
		.issue_tag(		issue_tag		),
		.alu_done(		alu_done		),
		.alu_tag(		alu_tag			),
		.alu_data(		alu_data		),
		.mul_done(		mul_done		),
		.mul_tag(		mul_tag			),
		.mul_data(		mul_data		)
	);

	reorder_buffer reorder_buffer (
		.clock(				clock			),
		.reset(				reset			),
		.alloc_valid(		alloc_valid		),
		.alloc_issue_no(	alloc_issue_no	),
		.alloc_dst(			alloc_dst		),
		.rob_full(			rob_full		),
		.alu_done(			alu_done		),
		.alu_tag(			alu_tag			),
		.alu_data(			alu_data		),
		.mul_done(			mul_done		),
		.mul_tag(			mul_tag			),
		.mul_data(			mul_data		),
		.wb_req(			wb_req			),
		.wb_idx(			wb_idx			),
		.wb_data(			wb_data			),
		.wb_gnt(			wb_gnt			),
		.retire_valid(		retire_valid	),
		.retire_dst(		retire_dst		),
		.commit_full(		commit_full		),
		.commit_push(		commit_push		),
		.commit_rec(		commit_rec		)
	);

	commit_port commit_port (
		.clock(				clock			),
		.reset(				reset			),
		.commit_push(		commit_push		),
		.commit_rec(		commit_rec		),
		.commit_full(		commit_full		),
		.commit_valid(		commit_valid	),
		.commit_issue_no(	commit_issue_no	),
		.commit_dst(		commit_dst		),
		.commit_data(		commit_data		),
		.commit_credit(		commit_credit	)
	);

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int	half_period		= 10,
	parameter int	reset_cycles	= 3
)(
	output	logic	clock,
	output	logic	reset
);

	initial begin
		clock = 1'b0;
		forever #(half_period) clock = ~clock;		// 20 ns period
	end

	// Held through the first rising edges
	initial begin
		reset = 1'b1;
		repeat ( reset_cycles ) @( posedge clock );
		reset <= 1'b0;
	end

endmodule

// ==== dv/simd_lane_tb.sv ====
`timescale 1ns/10ps
`include "lane_consts.svh"

module simd_lane_tb;
	import lane_pkg::*;

	localparam int			WAIT_LIMIT		= 2000;
	localparam int			RANDOM_COUNT	= 200;
	localparam int			HOLD_CYCLES		= 300;
	localparam logic [31:0]	LFSR_SEED		= 32'd88725;
	localparam logic [31:0]	LFSR_TAPS		= 32'h80200003;

	logic			clock;
	logic			reset;
	logic			cmd_valid;
	opcode_t		cmd_opcode;
	reg_idx_t		cmd_dst;
	reg_idx_t		cmd_src1;
	reg_idx_t		cmd_src2;
	logic [15:0]	cmd_imm;
	issue_no_t		cmd_issue_no;
	logic			cmd_credit;
	logic			commit_valid;
	issue_no_t		commit_issue_no;
	reg_idx_t		commit_dst;
	data_t			commit_data;
	logic			commit_credit;

	data_t			model_regs [`LANE_REG_COUNT];
	commit_t		expected_q [$];
	string			test_name		= "startup";
	int				mismatch_count	= 0;
	int				failure_count	= 0;
	int				sent_count		= 0;
	int				sent_seen		= 0;
	int				credit_count	= 0;
	int				commit_count	= 0;
	int				grants_given	= 0;
	int				credit_gap		= 0;
	logic			hold_credits	= 1'b0;
	bit				timed_out		= 1'b0;
	issue_no_t		next_issue_no	= '0;
	logic [31:0]	lfsr_cmd		= LFSR_SEED;
	logic [31:0]	lfsr_credit		= LFSR_SEED;

	tb_clock_gen clock_gen (
		.clock(	clock	),
		.reset(	reset	)
	);

	simd_lane uut (
		.clock(				clock			),
		.reset(				reset			),
		.cmd_valid(			cmd_valid		),
		.cmd_opcode(		cmd_opcode		),
		.cmd_dst(			cmd_dst			),
		.cmd_src1(			cmd_src1		),
		.cmd_src2(			cmd_src2		),
		.cmd_imm(			cmd_imm			),
		.cmd_issue_no(		cmd_issue_no	),
		.cmd_credit(		cmd_credit		),
		.commit_valid(		commit_valid	),
		.commit_issue_no(	commit_issue_no	),
		.commit_dst(		commit_dst		),
		.commit_data(		commit_data		),
		.commit_credit(		commit_credit	)
	);

	//////////////////////////////////////////////////
	// Random source and reference model
	//////////////////////////////////////////////////
	function automatic logic [31:0] lfsr_next( input logic [31:0] state );
		logic [31:0] shifted;
		shifted = state >> 1;
		if ( state[0] ) shifted = shifted ^ LFSR_TAPS;
		return shifted;
	endfunction

	// One step per bit taken
	task automatic take_bits( inout logic [31:0] state, input int count,
			output logic [31:0] value );
		value = '0;
		for ( int i = 0; i < count; i++ ) begin
			value = { value[30:0], state[0] };
			state = lfsr_next(state);
		end
	endtask

	function automatic data_t expected_result( input opcode_t op, input data_t a, input data_t b,
			input logic [15:0] imm );
		logic [63:0] product;
		product = { 32'b0, a } * { 32'b0, b };
		case ( op )
			OP_ADD:		return a + b;
			OP_SUB:		return a - b;
			OP_AND:		return a & b;
			OP_XOR:		return a ^ b;
			OP_MUL:		return product[31:0];
			OP_MOVI:	return { 16'h0000, imm };
			default:	return 'x;
		endcase
	endfunction

	task automatic model_command( input opcode_t op, input reg_idx_t dst, input reg_idx_t src1,
			input reg_idx_t src2, input logic [15:0] imm, input issue_no_t issue_no );
		commit_t rec;
		rec.issue_no	= issue_no;
		rec.dst			= dst;
		rec.data		= expected_result(op, model_regs[src1], model_regs[src2], imm);
		model_regs[dst]	= rec.data;
		expected_q.push_back(rec);
	endtask

	// Four-register pool, r8 to r11, so chains form often
	task automatic random_command( output opcode_t op, output reg_idx_t dst, output reg_idx_t src1,
			output reg_idx_t src2, output logic [15:0] imm );
		logic [31:0] bits;
		take_bits(lfsr_cmd, 3, bits);
		op = opcode_t'(bits[2:0] % 3'd6);
		take_bits(lfsr_cmd, 2, bits);
		dst = { 2'b10, bits[1:0] };
		take_bits(lfsr_cmd, 2, bits);
		src1 = { 2'b10, bits[1:0] };
		take_bits(lfsr_cmd, 2, bits);
		src2 = { 2'b10, bits[1:0] };
		take_bits(lfsr_cmd, 16, bits);
		imm = bits[15:0];
	endtask

	//////////////////////////////////////////////////
	// Command sender
	//////////////////////////////////////////////////
	task automatic drive_command( input opcode_t op, input reg_idx_t dst, input reg_idx_t src1,
			input reg_idx_t src2, input logic [15:0] imm );
		cmd_valid		<= 1'b1;
		cmd_opcode		<= op;
		cmd_dst			<= dst;
		cmd_src1		<= src1;
		cmd_src2		<= src2;
		cmd_imm			<= imm;
		cmd_issue_no	<= next_issue_no;
		model_command(op, dst, src1, src2, imm, next_issue_no);
		next_issue_no	= next_issue_no + 1'b1;
		sent_count++;
	endtask

	task automatic send_command( input opcode_t op, input reg_idx_t dst, input reg_idx_t src1,
			input reg_idx_t src2, input logic [15:0] imm );
		int waited;
		waited = 0;
		if ( timed_out ) return;
		@( posedge clock );
		cmd_valid <= 1'b0;
		while ( sent_count - credit_count >= `LANE_CMD_DEPTH ) begin
			if ( waited >= WAIT_LIMIT ) begin
				failure_count++;
				timed_out = 1'b1;
				$display("%s: timeout waiting for a command credit", test_name);
				return;
			end
			waited++;
			@( posedge clock );
			cmd_valid <= 1'b0;
		end
		drive_command(op, dst, src1, src2, imm);
	endtask

	task automatic drain;
		int waited;
		waited = 0;
		if ( timed_out ) return;
		@( posedge clock );
		cmd_valid <= 1'b0;
		while ( expected_q.size() != 0 ) begin
			if ( waited >= WAIT_LIMIT ) begin
				failure_count++;
				timed_out = 1'b1;
				$display("%s: timeout with %0d commits still missing", test_name,
					expected_q.size());
				return;
			end
			waited++;
			@( posedge clock );
		end
	endtask

	// Never grants more commit credits than commands sent
	initial begin
		logic [31:0] bits;
		commit_credit = 1'b0;
		forever begin
			@( posedge clock );
			if ( reset || hold_credits || grants_given >= sent_seen ) begin
				commit_credit <= 1'b0;
			end
			else if ( credit_gap != 0 ) begin
				commit_credit <= 1'b0;
				credit_gap--;
			end
			else begin
				commit_credit <= 1'b1;
				grants_given++;
				take_bits(lfsr_credit, 3, bits);
				credit_gap = bits;
			end
		end
	end

	//////////////////////////////////////////////////
	// Monitors and compare
	//////////////////////////////////////////////////
	task automatic report_mismatch( input string field, input logic [31:0] want,
			input logic [31:0] got );
		mismatch_count++;
		$display("mismatch %s %s expected %0h actual %0h", test_name, field, want, got);
	endtask

	always @( negedge clock ) begin
		if ( cmd_credit === 1'b1 ) credit_count++;
		sent_seen = sent_count;
		assert ( credit_count <= sent_count ) else begin
			failure_count++;
			$display("%s: %0d cmd_credit pulses for only %0d commands sent", test_name,
				credit_count, sent_count);
		end
	end

	always @( negedge clock ) begin : compare_commits
		commit_t exp_rec;
		if ( reset === 1'b0 && commit_valid !== 1'b0 ) begin
			commit_count++;
			assert ( expected_q.size() != 0 ) else begin
				failure_count++;
				$display("%s: commit of issue number %0h arrived with none outstanding",
					test_name, commit_issue_no);
			end
			if ( expected_q.size() != 0 ) begin
				exp_rec = expected_q.pop_front();
				assert ( commit_issue_no === exp_rec.issue_no ) else
					report_mismatch("issue_no", exp_rec.issue_no, commit_issue_no);
				assert ( commit_dst === exp_rec.dst ) else
					report_mismatch("dst", exp_rec.dst, commit_dst);
				assert ( commit_data === exp_rec.data ) else
					report_mismatch("data", exp_rec.data, commit_data);
			end
		end
	end

	//////////////////////////////////////////////////
	// Test phases
	//////////////////////////////////////////////////
	task automatic check_idle;
		test_name = "idle_after_reset";
		repeat ( 20 ) begin
			@( negedge clock );
			assert ( commit_valid === 1'b0 && cmd_credit === 1'b0 ) else begin
				failure_count++;
				$display("%s: commit_valid or cmd_credit went high with no command sent", test_name);
			end
		end
	endtask

	task automatic run_alu_sequence;
		test_name = "alu_sequence";
		send_command(OP_MOVI, 4'd1, 4'd0, 4'd0, 16'h1234);
		send_command(OP_MOVI, 4'd2, 4'd0, 4'd0, 16'h00ff);
		send_command(OP_ADD, 4'd3, 4'd1, 4'd2, 16'h0000);
		send_command(OP_SUB, 4'd4, 4'd2, 4'd1, 16'h0000);		// Wraps below zero
		send_command(OP_AND, 4'd5, 4'd3, 4'd4, 16'h0000);
		send_command(OP_XOR, 4'd6, 4'd5, 4'd1, 16'h0000);
		send_command(OP_MOVI, 4'd7, 4'd0, 4'd0, 16'hffff);
		send_command(OP_ADD, 4'd7, 4'd7, 4'd4, 16'h0000);
		send_command(OP_SUB, 4'd1, 4'd6, 4'd7, 16'h0000);
		send_command(OP_XOR, 4'd2, 4'd2, 4'd2, 16'h0000);
		drain();
	endtask

	task automatic run_mul_chains;
		test_name = "mul_chains";
		send_command(OP_MOVI, 4'd1, 4'd0, 4'd0, 16'h0003);
		send_command(OP_MUL, 4'd2, 4'd1, 4'd1, 16'h0000);
		send_command(OP_ADD, 4'd3, 4'd2, 4'd1, 16'h0000);
		send_command(OP_MUL, 4'd4, 4'd3, 4'd2, 16'h0000);
		send_command(OP_MUL, 4'd5, 4'd4, 4'd4, 16'h0000);
		send_command(OP_MOVI, 4'd6, 4'd0, 4'd0, 16'hffff);
		send_command(OP_MUL, 4'd7, 4'd6, 4'd6, 16'h0000);
		send_command(OP_MUL, 4'd9, 4'd7, 4'd7, 16'h0000);		// High bits dropped
		send_command(OP_MOVI, 4'd10, 4'd0, 4'd0, 16'h0006);		// Finishes before r9
		send_command(OP_XOR, 4'd11, 4'd9, 4'd5, 16'h0000);
		send_command(OP_SUB, 4'd12, 4'd10, 4'd11, 16'h0000);
		send_command(OP_MUL, 4'd13, 4'd12, 4'd3, 16'h0000);
		send_command(OP_AND, 4'd14, 4'd13, 4'd7, 16'h0000);
		drain();
	endtask

	task automatic run_credit_hold;
		opcode_t		op;
		reg_idx_t		dst;
		reg_idx_t		src1;
		reg_idx_t		src2;
		logic [15:0]	imm;
		int				commits_before;
		int				credits_late;
		if ( timed_out ) return;
		test_name		= "commit_backpressure";
		hold_credits	<= 1'b1;
		commits_before	= commit_count;
		credits_late	= 0;
		for ( int cycle = 0; cycle < HOLD_CYCLES; cycle++ ) begin
			@( posedge clock );
			cmd_valid <= 1'b0;
			if ( cycle == HOLD_CYCLES - 100 ) credits_late = credit_count;
			if ( sent_count - credit_count < `LANE_CMD_DEPTH ) begin
				random_command(op, dst, src1, src2, imm);
				drive_command(op, dst, src1, src2, imm);
			end
		end
		assert ( commit_count == commits_before ) else begin
			failure_count++;
			$display("%s: commits went out while no credit was granted", test_name);
		end
		assert ( sent_count - credit_count == `LANE_CMD_DEPTH ) else begin
			failure_count++;
			$display("%s: sender still held credits with the lane stalled", test_name);
		end
		assert ( credit_count == credits_late ) else begin
			failure_count++;
			$display("%s: cmd_credit kept pulsing after the queues filled", test_name);
		end
		hold_credits <= 1'b0;
		drain();
	endtask

	task automatic run_random_stream;
		opcode_t		op;
		reg_idx_t		dst;
		reg_idx_t		src1;
		reg_idx_t		src2;
		logic [15:0]	imm;
		test_name = "random_stream";
		for ( int n = 0; n < RANDOM_COUNT; n++ ) begin
			random_command(op, dst, src1, src2, imm);
			send_command(op, dst, src1, src2, imm);
		end
		drain();
		assert ( timed_out || credit_count == sent_count ) else begin
			failure_count++;
			$display("%s: %0d cmd_credit pulses for %0d commands sent", test_name,
				credit_count, sent_count);
		end
	endtask

	task automatic finish_run;
		$display("error counts: mismatch=%0d other=%0d", mismatch_count, failure_count);
		if ( mismatch_count == 0 && failure_count == 0 ) begin
			$display("NO ERRORS");
		end
		else begin
			$display("ERRORS FOUND");
		end
		$finish;
	endtask

	initial begin
		int waited;
		cmd_valid		= 1'b0;
		cmd_opcode		= OP_ADD;
		cmd_dst			= '0;
		cmd_src1		= '0;
		cmd_src2		= '0;
		cmd_imm			= '0;
		cmd_issue_no	= '0;
		for ( int i = 0; i < `LANE_REG_COUNT; i++ ) begin
			model_regs[i] = '0;
		end
		waited = 0;
		while ( reset !== 1'b0 && !timed_out ) begin
			@( posedge clock );
			waited++;
			if ( waited > WAIT_LIMIT ) begin
				failure_count++;
				timed_out = 1'b1;
				$display("timeout waiting for reset to be released");
			end
		end
		check_idle();
		run_alu_sequence();
		run_mul_chains();
		run_credit_hold();
		run_random_stream();
		finish_run();
	end

endmodule

// ==== simd_lane.f ====
+incdir+logic
logic/lane_pkg.sv
logic/queue_fifo.sv
logic/operand_fetch.sv
logic/rf_arbiter.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/reorder_buffer.sv
logic/commit_port.sv
logic/simd_lane.sv
dv/tb_clock_gen.sv
dv/simd_lane_tb.sv
